// File: compile.f
hw/nasti_pkg.sv
hw/nasti_if.sv
hw/bram_block.sv
hw/ram_port_arbiter.sv
hw/nasti_write_engine.sv
hw/nasti_read_engine.sv
hw/nasti_bram_top.sv
tests/nasti_bram_props.sv
tests/tb_nasti_bram.sv

// File: run.sh
#!/bin/sh
# build and run the NASTI block RAM testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_nasti_bram -Mdir obj_dir -f compile.f
./obj_dir/Vtb_nasti_bram | tee sim.log
if grep -qx "RESULT: PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: tests/tb_nasti_bram.sv
// --------------------------------------------------------------------------
// testbench for the NASTI block RAM slave, random bursts against a ref memory
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_nasti_bram;

   localparam int N_SINGLE = 8;
   localparam int N_INCR   = 24;
   localparam int N_FIXED  = 4;
   localparam int N_ERR    = 4;
   localparam int N_STREAM = 16;
   localparam int N_TRANS  = 4 + 2*N_SINGLE + 2*N_INCR + 2*N_FIXED + 3*N_ERR + 2*N_STREAM + 2;
   localparam int WATCHDOG_CYCLES = N_TRANS * 256 * 4;   // longest burst at 4 cycles a beat

   logic                                      clk;
   logic                                      arst_n;
   logic                                      aw_valid, aw_ready, ar_valid, ar_ready;
   logic                                      w_last, w_valid, w_ready;
   logic                                      b_valid, b_ready;
   logic                                      r_last, r_valid, r_ready;
   nasti_pkg::id_t                            aw_id, ar_id, b_id, r_id;
   nasti_pkg::addr_t                          aw_addr, ar_addr;
   nasti_pkg::len_t                           aw_len, ar_len;
   nasti_pkg::size_t                          aw_size, ar_size;
   nasti_pkg::burst_t                         aw_burst, ar_burst;
   nasti_pkg::data_t                          w_data, r_data;
   nasti_pkg::strb_t                          w_strb;
   nasti_pkg::resp_t                          b_resp, r_resp;

   nasti_pkg::data_t ref_mem [nasti_pkg::RAM_WORDS];
   logic [31:0]      rand_state = 32'd98004;
   int               checks;
   int               errors;

   nasti_bram_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return {rand_state[15:0], rand_state[31:16]};   // high bits are the better ones
   endfunction

   function automatic nasti_pkg::addr_t random_addr(int first, int span);
      return nasti_pkg::addr_t'((first + int'(next_rand() % span)) * 8);
   endfunction

   function automatic nasti_pkg::data_t fill_word(int idx);
      return nasti_pkg::data_t'(idx + 1) * 64'h9E37_79B9_7F4A_7C15;
   endfunction

   // full-width beats, FIXED or INCR, and every beat inside the RAM
   function automatic logic expect_slverr(nasti_pkg::addr_t addr, nasti_pkg::len_t len,
                                          nasti_pkg::size_t size, nasti_pkg::burst_t burst);
      int last_idx;
      last_idx = int'(addr >> 3);
      if (burst == nasti_pkg::BURST_INCR)
         last_idx = last_idx + int'(len);
      return (size != 3'd3) || (burst > nasti_pkg::BURST_INCR) || (last_idx >= 1024);
   endfunction

   function automatic nasti_pkg::resp_t expected_resp(logic err);
      return err ? nasti_pkg::RESP_SLVERR : nasti_pkg::RESP_OKAY;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic merge_beat(input int idx, input nasti_pkg::data_t data,
                             input nasti_pkg::strb_t strb);
      int i;
      for (i = 0; i < 8; i++) begin
         if (strb[i])
            ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
   endtask

   task automatic write_burst(input nasti_pkg::id_t id, input nasti_pkg::addr_t addr,
                              input nasti_pkg::len_t len, input nasti_pkg::size_t size,
                              input nasti_pkg::burst_t burst, input logic fill);
      logic err;
      logic hs;
      int   idx;
      int   beat;
      err      = expect_slverr(addr, len, size, burst);
      idx      = int'(addr >> 3);
      aw_id    = id;
      aw_addr  = addr;
      aw_len   = len;
      aw_size  = size;
      aw_burst = burst;
      aw_valid = 1'b1;
      do begin
         #1;
         hs = aw_ready;
         @(negedge clk);
      end while (!hs);
      aw_valid = 1'b0;
      for (beat = 0; beat <= int'(len); beat++) begin
         w_data  = fill ? fill_word(idx) : {next_rand(), next_rand()};
         w_strb  = fill ? '1 : nasti_pkg::strb_t'(next_rand());
         w_last  = (beat == int'(len));
         w_valid = 1'b1;
         do begin
            #1;
            hs = w_ready;
            @(negedge clk);
         end while (!hs);
         if (!err)
            merge_beat(idx, w_data, w_strb);
         if (burst == nasti_pkg::BURST_INCR)
            idx++;
      end
      w_valid = 1'b0;
      w_last  = 1'b0;
      do begin
         b_ready = (next_rand() % 4) != 0;   // random back-pressure
         #1;
         hs = b_valid && b_ready;
         if (hs) begin
            check_value("b_id", 64'(b_id), 64'(id));
            check_value("b_resp", 64'(b_resp), 64'(expected_resp(err)));
         end
         @(negedge clk);
      end while (!hs);
      b_ready = 1'b0;
   endtask

   task automatic read_burst(input nasti_pkg::id_t id, input nasti_pkg::addr_t addr,
                             input nasti_pkg::len_t len, input nasti_pkg::size_t size,
                             input nasti_pkg::burst_t burst);
      logic             err;
      logic             hs;
      int               idx;
      int               beat;
      nasti_pkg::data_t exp_data;
      err      = expect_slverr(addr, len, size, burst);
      idx      = int'(addr >> 3);
      ar_id    = id;
      ar_addr  = addr;
      ar_len   = len;
      ar_size  = size;
      ar_burst = burst;
      ar_valid = 1'b1;
      do begin
         #1;
         hs = ar_ready;
         @(negedge clk);
      end while (!hs);
      ar_valid = 1'b0;
      beat     = 0;
      while (beat <= int'(len)) begin
         r_ready = (next_rand() % 4) != 0;
         #1;
         if (r_valid && r_ready) begin
            if (err)
               exp_data = '0;   // error beats carry no data
            else
               exp_data = ref_mem[idx];
            check_value("r_data", r_data, exp_data);
            check_value("r_id", 64'(r_id), 64'(id));
            check_value("r_resp", 64'(r_resp), 64'(expected_resp(err)));
            check_value("r_last", 64'(r_last), 64'(beat == int'(len)));
            beat++;
            if (burst == nasti_pkg::BURST_INCR)
               idx++;
         end
         @(negedge clk);
      end
      r_ready = 1'b0;
   endtask

   task automatic write_stream();
      int s;
      for (s = 0; s < N_STREAM; s++) begin
         write_burst(nasti_pkg::id_t'(next_rand()), random_addr(0, 512 - 16),
                     nasti_pkg::len_t'(next_rand() % 16), 3'd3, nasti_pkg::BURST_INCR, 1'b0);
      end
   endtask

   task automatic read_stream();
      int s;
      for (s = 0; s < N_STREAM; s++) begin
         read_burst(nasti_pkg::id_t'(next_rand()), random_addr(512, 512 - 16),
                    nasti_pkg::len_t'(next_rand() % 16), 3'd3, nasti_pkg::BURST_INCR);
      end
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the DUT did not finish all transactions in %0d cycles",
               WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      nasti_pkg::addr_t  addr;
      nasti_pkg::len_t   len;
      nasti_pkg::size_t  size;
      nasti_pkg::burst_t burst;
      int                k;
      checks   = 0;
      errors   = 0;
      arst_n   = 1'b0;
      aw_id    = '0;
      aw_addr  = '0;
      aw_len   = '0;
      aw_size  = '0;
      aw_burst = '0;
      aw_valid = 1'b0;
      w_data   = '0;
      w_strb   = '0;
      w_last   = 1'b0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar_id    = '0;
      ar_addr  = '0;
      ar_len   = '0;
      ar_size  = '0;
      ar_burst = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      #1;
      check_value("b_valid", 64'(b_valid), 64'd0);
      check_value("r_valid", 64'(r_valid), 64'd0);
      @(negedge clk);

      // whole RAM gets a known pattern first
      for (k = 0; k < 4; k++)
         write_burst('0, nasti_pkg::addr_t'(k * 2048), 8'd255, 3'd3, nasti_pkg::BURST_INCR, 1'b1);

      for (k = 0; k < N_SINGLE; k++) begin
         addr = random_addr(0, 1024);
         write_burst(nasti_pkg::id_t'(next_rand()), addr, '0, 3'd3, nasti_pkg::BURST_INCR, 1'b0);
         read_burst(nasti_pkg::id_t'(next_rand()), addr, '0, 3'd3, nasti_pkg::BURST_INCR);
      end

      for (k = 0; k < N_INCR; k++) begin
         len  = nasti_pkg::len_t'(next_rand() % 16);
         addr = random_addr(0, 1024 - 16);
         write_burst(nasti_pkg::id_t'(next_rand()), addr, len, 3'd3, nasti_pkg::BURST_INCR, 1'b0);
         read_burst(nasti_pkg::id_t'(next_rand()), addr, len, 3'd3, nasti_pkg::BURST_INCR);
      end

      for (k = 0; k < N_FIXED; k++) begin
         len  = nasti_pkg::len_t'(1 + next_rand() % 7);
         addr = random_addr(0, 1024);
         write_burst(nasti_pkg::id_t'(next_rand()), addr, len, 3'd3, nasti_pkg::BURST_FIXED, 1'b0);
         read_burst(nasti_pkg::id_t'(next_rand()), addr, 8'd2, 3'd3, nasti_pkg::BURST_FIXED);
      end

      for (k = 0; k < N_ERR; k++) begin
         size  = 3'd3;
         burst = nasti_pkg::BURST_INCR;
         case (k)
            0: begin
               addr = random_addr(0, 1000);
               size = 3'd2;   // narrow beat
            end
            1: begin
               addr  = random_addr(0, 1000);
               burst = 2'd2;   // WRAP
            end
            2: addr = nasti_pkg::addr_t'(1020 * 8);   // runs past the last word
            default: begin
               addr  = 16'hF000;
               burst = nasti_pkg::BURST_FIXED;
            end
         endcase
         write_burst(nasti_pkg::id_t'(next_rand()), addr, 8'd7, size, burst, 1'b0);
         read_burst(nasti_pkg::id_t'(next_rand()), addr, 8'd7, size, burst);
         read_burst(nasti_pkg::id_t'(next_rand()), addr & 16'h1FF8, '0, 3'd3,
                    nasti_pkg::BURST_INCR);
      end

      fork
         write_stream();
         read_stream();
      join
      read_burst('0, 16'h0000, 8'd255, 3'd3, nasti_pkg::BURST_INCR);
      read_burst('0, 16'h0800, 8'd255, 3'd3, nasti_pkg::BURST_INCR);

      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               dut_i.props_i.fail_cnt);
      if (errors == 0 && dut_i.props_i.fail_cnt == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: tests/nasti_bram_props.sv
// --------------------------------------------------------------------------
// bound NASTI checks on channel stability, reset values and response order
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module nasti_bram_props (
   input logic              clk,
   input logic              arst_n,
   input logic              aw_valid, aw_ready, ar_valid, ar_ready,
   input logic              w_last, w_valid, w_ready,
   input logic              b_valid, b_ready,
   input logic              r_last, r_valid, r_ready,
   input nasti_pkg::id_t    aw_id, ar_id, b_id, r_id,
   input nasti_pkg::addr_t  aw_addr, ar_addr,
   input nasti_pkg::len_t   aw_len, ar_len,
   input nasti_pkg::size_t  aw_size, ar_size,
   input nasti_pkg::burst_t aw_burst, ar_burst,
   input nasti_pkg::data_t  w_data, r_data,
   input nasti_pkg::strb_t  w_strb,
   input nasti_pkg::resp_t  b_resp, r_resp
);

   logic [8:0]      r_beat_q;   // beats popped in this burst
   nasti_pkg::len_t ar_len_q;
   int              fail_cnt = 0;   // failed assertions so far

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r_beat_q <= '0;
         ar_len_q <= '0;
      end else if (ar_valid && ar_ready) begin
         r_beat_q <= '0;
         ar_len_q <= ar_len;
      end else if (r_valid && r_ready) begin
         r_beat_q <= r_beat_q + 9'd1;
      end
   end

   a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
      aw_valid && !aw_ready |=> aw_valid && $stable({aw_id, aw_addr, aw_len, aw_size, aw_burst}))
      else begin
         fail_cnt++;
         $error("AW valid or payload changed before ready");
      end
   a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
      w_valid && !w_ready |=> w_valid && $stable({w_data, w_strb, w_last}))
      else begin
         fail_cnt++;
         $error("W valid or payload changed before ready");
      end
   a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable({ar_id, ar_addr, ar_len, ar_size, ar_burst}))
      else begin
         fail_cnt++;
         $error("AR valid or payload changed before ready");
      end
   a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
      b_valid && !b_ready |=> b_valid && $stable({b_id, b_resp}))
      else begin
         fail_cnt++;
         $error("B valid or payload changed before ready");
      end
   a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
      r_valid && !r_ready |=> r_valid && $stable({r_id, r_data, r_resp, r_last}))
      else begin
         fail_cnt++;
         $error("R valid or payload changed before ready");
      end

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !b_valid && !r_valid)
      else begin
         fail_cnt++;
         $error("response valid high during reset");
      end
   a_b_after_last: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(b_valid) |-> $past(w_valid && w_ready && w_last))
      else begin
         fail_cnt++;
         $error("B response without a preceding last W beat");
      end
   a_r_last: assert property (@(posedge clk) disable iff (!arst_n)
      r_valid |-> (r_last == (r_beat_q == {1'b0, ar_len_q})))
      else begin
         fail_cnt++;
         $error("r_last does not match the burst length");
      end

endmodule

bind nasti_bram_top nasti_bram_props props_i (.*);

// File: hw/nasti_bram_top.sv
// --------------------------------------------------------------------------
// NASTI block RAM slave: channel ports, engines, port arbiter and RAM
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module nasti_bram_top (
   input  logic              clk,
   input  logic              arst_n,
   input  nasti_pkg::id_t    aw_id,
   input  nasti_pkg::addr_t  aw_addr,
   input  nasti_pkg::len_t   aw_len,
   input  nasti_pkg::size_t  aw_size,
   input  nasti_pkg::burst_t aw_burst,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  nasti_pkg::data_t  w_data,
   input  nasti_pkg::strb_t  w_strb,
   input  logic              w_last,
   input  logic              w_valid,
   output logic              w_ready,
   output nasti_pkg::id_t    b_id,
   output nasti_pkg::resp_t  b_resp,
   output logic              b_valid,
   input  logic              b_ready,
   input  nasti_pkg::id_t    ar_id,
   input  nasti_pkg::addr_t  ar_addr,
   input  nasti_pkg::len_t   ar_len,
   input  nasti_pkg::size_t  ar_size,
   input  nasti_pkg::burst_t ar_burst,
   input  logic              ar_valid,
   output logic              ar_ready,
   output nasti_pkg::id_t    r_id,
   output nasti_pkg::data_t  r_data,
   output nasti_pkg::resp_t  r_resp,
   output logic              r_last,
   output logic              r_valid,
   input  logic              r_ready
);

   nasti_addr_if aw_if ();
   nasti_w_if    w_if ();
   nasti_b_if    b_if ();
   nasti_addr_if ar_if ();
   nasti_r_if    r_if ();
   ram_port_if   wr_ram_if ();
   ram_port_if   rd_ram_if ();
   ram_port_if   mem_if ();

   assign aw_if.id    = aw_id;
   assign aw_if.addr  = aw_addr;
   assign aw_if.len   = aw_len;
   assign aw_if.size  = aw_size;
   assign aw_if.burst = aw_burst;
   assign aw_if.valid = aw_valid;
   assign aw_ready    = aw_if.ready;

   assign w_if.data  = w_data;
   assign w_if.strb  = w_strb;
   assign w_if.last  = w_last;
   assign w_if.valid = w_valid;
   assign w_ready    = w_if.ready;

   assign b_id       = b_if.id;
   assign b_resp     = b_if.resp;
   assign b_valid    = b_if.valid;
   assign b_if.ready = b_ready;

   assign ar_if.id    = ar_id;
   assign ar_if.addr  = ar_addr;
   assign ar_if.len   = ar_len;
   assign ar_if.size  = ar_size;
   assign ar_if.burst = ar_burst;
   assign ar_if.valid = ar_valid;
   assign ar_ready    = ar_if.ready;

   assign r_id       = r_if.id;
   assign r_data     = r_if.data;
   assign r_resp     = r_if.resp;
   assign r_last     = r_if.last;
   assign r_valid    = r_if.valid;
   assign r_if.ready = r_ready;

   nasti_write_engine wr_eng_i (
      .clk    (clk),
      .arst_n (arst_n),
      .aw     (aw_if),
      .w      (w_if),
      .b      (b_if),
      .ram    (wr_ram_if)
   );

   nasti_read_engine rd_eng_i (
      .clk    (clk),
      .arst_n (arst_n),
      .ar     (ar_if),
      .r      (r_if),
      .ram    (rd_ram_if)
   );

   ram_port_arbiter arb_i (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr_ram_if),
      .rd     (rd_ram_if),
      .mem    (mem_if)
   );

   bram_block ram_i (
      .clk (clk),
      .mem (mem_if)
   );

endmodule

// File: hw/nasti_read_engine.sv
// --------------------------------------------------------------------------
// NASTI read engine: takes AR, reads RAM per beat, returns R via 2-entry FIFO
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module nasti_read_engine (
   input logic                clk,
   input logic                arst_n,
   nasti_addr_if.slave        ar,
   nasti_r_if.master          r,
   ram_port_if.client         ram
);

   nasti_pkg::rd_state_e state_q, state_d;
   logic                 ar_rdy_q;
   logic                 err_q;
   logic                 fixed_q;
   nasti_pkg::id_t       id_q;
   nasti_pkg::idx_t      idx_q;
   logic [8:0]           left_q;   // beats still to issue
   logic                 pend_q;   // beat in the RAM
   logic                 pend_last_q;
   logic [1:0]           cnt_q;
   logic                 wr_ptr_q;
   logic                 rd_ptr_q;
   nasti_pkg::data_t     buf_data_q [2];
   nasti_pkg::resp_t     buf_resp_q [2];
   nasti_pkg::id_t       buf_id_q   [2];
   logic                 buf_last_q [2];
   logic [2:0]           used;
   logic                 issue_ok;
   logic                 issue;
   logic                 pop;
   logic                 ar_hs;

   assign ar.ready = ar_rdy_q;
   assign ar_hs    = ar.valid && ar.ready;

   assign r.valid = (cnt_q != 2'd0);
   assign r.data  = buf_data_q[rd_ptr_q];
   assign r.resp  = buf_resp_q[rd_ptr_q];
   assign r.id    = buf_id_q[rd_ptr_q];
   assign r.last  = buf_last_q[rd_ptr_q];
   assign pop     = r.valid && r.ready;

   // slots taken once this cycle's pop and the pending push settle
   assign used     = {1'b0, cnt_q} + {2'b0, pend_q} - {2'b0, pop};
   assign issue_ok = (state_q == nasti_pkg::RD_BURST) && (left_q != '0) && (used < 3'd2);
   assign issue    = issue_ok && (err_q || ram.grant);

   assign ram.req    = issue_ok && !err_q;
   assign ram.we     = 1'b0;
   assign ram.idx    = idx_q;
   assign ram.wrdata = '0;
   assign ram.strb   = '0;

   always_comb begin
      state_d = state_q;
      case (state_q)
         nasti_pkg::RD_IDLE:  if (ar_hs) state_d = nasti_pkg::RD_BURST;
         nasti_pkg::RD_BURST: if (pop && r.last) state_d = nasti_pkg::RD_IDLE;
         default: state_d = nasti_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q     <= nasti_pkg::RD_IDLE;
         ar_rdy_q    <= 1'b0;
         err_q       <= 1'b0;
         left_q      <= '0;
         pend_q      <= 1'b0;
         pend_last_q <= 1'b0;
         cnt_q       <= 2'd0;
         wr_ptr_q    <= 1'b0;
         rd_ptr_q    <= 1'b0;
      end else begin
         state_q     <= state_d;
         ar_rdy_q    <= (state_d == nasti_pkg::RD_IDLE);
         pend_q      <= issue;
         pend_last_q <= issue && (left_q == 9'd1);
         cnt_q       <= cnt_q + {1'b0, pend_q} - {1'b0, pop};
         if (pend_q)
            wr_ptr_q <= !wr_ptr_q;
         if (pop)
            rd_ptr_q <= !rd_ptr_q;
         if (ar_hs) begin
            err_q  <= nasti_pkg::burst_err(ar.addr, ar.len, ar.size, ar.burst);
            left_q <= {1'b0, ar.len} + 9'd1;
         end else if (issue) begin
            left_q <= left_q - 9'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         id_q    <= ar.id;
         idx_q   <= ar.addr[3 +: nasti_pkg::IDX_W];
         fixed_q <= (ar.burst == nasti_pkg::BURST_FIXED);
      end else if (issue && !fixed_q) begin
         idx_q <= idx_q + 1'b1;
      end
      if (pend_q) begin
         buf_data_q[wr_ptr_q] <= err_q ? '0 : ram.rddata;   // error beats read as zero
         buf_resp_q[wr_ptr_q] <= err_q ? nasti_pkg::RESP_SLVERR : nasti_pkg::RESP_OKAY;
         buf_id_q[wr_ptr_q]   <= id_q;
         buf_last_q[wr_ptr_q] <= pend_last_q;
      end
   end

endmodule

// File: hw/nasti_write_engine.sv
// --------------------------------------------------------------------------
// NASTI write engine: takes AW and W, writes each beat to RAM, answers on B
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module nasti_write_engine (
   input logic                clk,
   input logic                arst_n,
   nasti_addr_if.slave        aw,
   nasti_w_if.slave           w,
   nasti_b_if.master          b,
   ram_port_if.client         ram
);

   nasti_pkg::wr_state_e state_q, state_d;
   logic                 aw_rdy_q;
   logic                 err_q;
   logic                 fixed_q;
   nasti_pkg::id_t       id_q;
   nasti_pkg::idx_t      idx_q;
   nasti_pkg::len_t      left_q;   // beats after the current one
   logic                 aw_hs;
   logic                 w_hs;

   assign aw.ready = aw_rdy_q;
   assign aw_hs    = aw.valid && aw.ready;
   assign w.ready  = (state_q == nasti_pkg::WR_DATA) && (err_q || ram.grant);
   assign w_hs     = w.valid && w.ready;

   assign ram.req    = (state_q == nasti_pkg::WR_DATA) && w.valid && !err_q;
   assign ram.we     = 1'b1;
   assign ram.idx    = idx_q;
   assign ram.wrdata = w.data;
   assign ram.strb   = w.strb;

   assign b.valid = (state_q == nasti_pkg::WR_RESP);
   assign b.id    = id_q;
   assign b.resp  = err_q ? nasti_pkg::RESP_SLVERR : nasti_pkg::RESP_OKAY;

   always_comb begin
      state_d = state_q;
      case (state_q)
         nasti_pkg::WR_IDLE: if (aw_hs) state_d = nasti_pkg::WR_DATA;
         nasti_pkg::WR_DATA: if (w_hs && w.last) state_d = nasti_pkg::WR_RESP;
         nasti_pkg::WR_RESP: if (b.valid && b.ready) state_d = nasti_pkg::WR_IDLE;
         default: state_d = nasti_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= nasti_pkg::WR_IDLE;
         aw_rdy_q <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         state_q  <= state_d;
         aw_rdy_q <= (state_d == nasti_pkg::WR_IDLE);
         if (aw_hs)
            err_q <= nasti_pkg::burst_err(aw.addr, aw.len, aw.size, aw.burst);
         else if (w_hs && (w.last != (left_q == '0)))
            err_q <= 1'b1;   // wlast disagrees with awlen
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         id_q    <= aw.id;
         idx_q   <= aw.addr[3 +: nasti_pkg::IDX_W];
         left_q  <= aw.len;
         fixed_q <= (aw.burst == nasti_pkg::BURST_FIXED);
      end else if (w_hs) begin
         if (left_q != '0)
            left_q <= left_q - 1'b1;
         if (!fixed_q)
            idx_q <= idx_q + 1'b1;
      end
   end

endmodule

// File: hw/ram_port_arbiter.sv
// --------------------------------------------------------------------------
// RAM port arbiter: one grant per cycle, alternating between write and read
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ram_port_arbiter (
   input logic          clk,
   input logic          arst_n,
   ram_port_if.arbiter  wr,
   ram_port_if.arbiter  rd,
   ram_port_if.client   mem
);

   logic last_wr_q;   // write side won the last grant
   logic wr_win;
   logic rd_win;

   // write wins unless both ask and it won last time
   assign wr_win = wr.req && (!rd.req || !last_wr_q);
   assign rd_win = rd.req && !wr_win;

   assign wr.grant = wr_win && mem.grant;
   assign rd.grant = rd_win && mem.grant;

   assign mem.req    = wr.req || rd.req;
   assign mem.we     = wr_win ? wr.we     : rd.we;
   assign mem.idx    = wr_win ? wr.idx    : rd.idx;
   assign mem.wrdata = wr_win ? wr.wrdata : rd.wrdata;
   assign mem.strb   = wr_win ? wr.strb   : rd.strb;

   assign rd.rddata = mem.rddata;
   assign wr.rddata = mem.rddata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         last_wr_q <= 1'b0;
      else if (mem.req && mem.grant)
         last_wr_q <= wr_win;
   end

endmodule

// File: hw/bram_block.sv
// --------------------------------------------------------------------------
// single-port block RAM with byte-enable writes and one cycle read latency
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module bram_block (
   input logic         clk,
   ram_port_if.memory  mem
);

   nasti_pkg::data_t ram_q [nasti_pkg::RAM_WORDS];
   nasti_pkg::data_t rddata_q;

   assign mem.grant  = 1'b1;   // port accepts every cycle
   assign mem.rddata = rddata_q;

   always_ff @(posedge clk) begin
      if (mem.req) begin
         if (mem.we) begin
            for (int i = 0; i < nasti_pkg::STRB_W; i++) begin
               if (mem.strb[i])
                  ram_q[mem.idx][8*i +: 8] <= mem.wrdata[8*i +: 8];
            end
         end else begin
            rddata_q <= ram_q[mem.idx];
         end
      end
   end

endmodule

// File: hw/nasti_if.sv
// --------------------------------------------------------------------------
// NASTI channel interfaces and the internal single-port RAM interface
// --------------------------------------------------------------------------
`timescale 1ns/1ps

interface nasti_addr_if;
   nasti_pkg::id_t    id;
   nasti_pkg::addr_t  addr;
   nasti_pkg::len_t   len;
   nasti_pkg::size_t  size;
   nasti_pkg::burst_t burst;
   logic              valid;
   logic              ready;
   modport master (output id, addr, len, size, burst, valid, input ready);
   modport slave  (input id, addr, len, size, burst, valid, output ready);
endinterface

interface nasti_w_if;
   nasti_pkg::data_t data;
   nasti_pkg::strb_t strb;
   logic             last;
   logic             valid;
   logic             ready;
   modport master (output data, strb, last, valid, input ready);
   modport slave  (input data, strb, last, valid, output ready);
endinterface

interface nasti_b_if;
   nasti_pkg::id_t   id;
   nasti_pkg::resp_t resp;
   logic             valid;
   logic             ready;
   modport master (output id, resp, valid, input ready);
   modport slave  (input id, resp, valid, output ready);
endinterface

interface nasti_r_if;
   nasti_pkg::id_t   id;
   nasti_pkg::data_t data;
   nasti_pkg::resp_t resp;
   logic             last;
   logic             valid;
   logic             ready;
   modport master (output id, data, resp, last, valid, input ready);
   modport slave  (input id, data, resp, last, valid, output ready);
endinterface

interface ram_port_if;
   logic             req;
   logic             we;
   nasti_pkg::idx_t  idx;
   nasti_pkg::data_t wrdata;
   nasti_pkg::strb_t strb;
   nasti_pkg::data_t rddata;   // valid the cycle after a read
   logic             grant;    // request taken on this edge
   modport client  (output req, we, idx, wrdata, strb, input rddata, grant);
   modport arbiter (input req, we, idx, wrdata, strb, output rddata, grant);
   modport memory  (input req, we, idx, wrdata, strb, output rddata, grant);
endinterface

// File: hw/nasti_pkg.sv
// --------------------------------------------------------------------------
// NASTI block RAM subsystem: shared widths, types, codes and FSM states
// --------------------------------------------------------------------------
package nasti_pkg;

   localparam int unsigned ADDR_W    = 16;
   localparam int unsigned DATA_W    = 64;
   localparam int unsigned STRB_W    = 8;
   localparam int unsigned ID_W      = 4;
   localparam int unsigned RAM_WORDS = 1024;
   localparam int unsigned IDX_W     = 10;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [IDX_W-1:0]  idx_t;
   typedef logic [7:0]        len_t;   // beats minus one
   typedef logic [2:0]        size_t;
   typedef logic [1:0]        burst_t;
   typedef logic [1:0]        resp_t;

   localparam size_t  FULL_SIZE   = 3'd3;   // 8 bytes per beat
   localparam burst_t BURST_FIXED = 2'd0;
   localparam burst_t BURST_INCR  = 2'd1;
   localparam resp_t  RESP_OKAY   = 2'd0;
   localparam resp_t  RESP_SLVERR = 2'd2;

   typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
   typedef enum logic {RD_IDLE, RD_BURST} rd_state_e;

   // true when a burst breaks the size, type or range rule
   function automatic logic burst_err(addr_t addr, len_t len, size_t size, burst_t burst);
      logic [ADDR_W-3:0] last_word;
      last_word = {1'b0, addr[ADDR_W-1:3]};
      if (burst == BURST_INCR)
         last_word = last_word + (ADDR_W-2)'(len);   // final beat of the burst
      return (size != FULL_SIZE) || (burst != BURST_FIXED && burst != BURST_INCR) ||
             (last_word >= RAM_WORDS);
   endfunction

endpackage
